// File: merge_data_generator.f
+incdir+include
logic/merge_config_pkg.sv
logic/memory_packet_pkg.sv
logic/merge_config_regs.sv
logic/index_sequencer.sv
logic/request_packer.sv
logic/request_fifo.sv
logic/merge_data_generator.sv
sim/merge_data_generator_tb.sv

// File: Makefile
# Verilator build and run for the index-sequence generator

TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = merge_data_generator_tb
RTL_TOP    = merge_data_generator
FILELIST   = merge_data_generator.f
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/merge_data_generator_tb.sv
// Table-driven testbench for the index-sequence generator.
// Each row starts one job and checks every request against a reference model.
`timescale 1ns/1ps
`default_nettype none

`include "merge_data_gen_settings.svh"

module merge_data_generator_tb
    import merge_config_pkg::*;
    import memory_packet_pkg::*;
();

    localparam int NUM_ROWS     = 9;
    localparam int RD_ALWAYS    = 0;
    localparam int RD_RANDOM    = 1;
    localparam int RD_HOLD      = 2;
    localparam int HOLD_CYCLES  = 100;
    localparam int REQ_TIMEOUT  = 3000;
    localparam int DONE_TIMEOUT = 200;
    localparam int QUIET_CYCLES = 20;

    logic            ap_clk;
    logic            areset_generator;
    logic            config_valid;
    merge_config_t   job_config;
    logic            request_rd_en;
    logic            request_valid;
    memory_request_t request;
    logic            done;

    merge_config_t   row_cfg [NUM_ROWS];
    int              row_mode [NUM_ROWS];
    logic            row_extra [NUM_ROWS];
    memory_request_t expected_q [$];
    logic [31:0]     lfsr_state;
    int              error_count;
    int              checked_count;
    int              rows_filled;
    int              row;
    logic            aborted;

    merge_data_generator DUT (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_valid     (config_valid),
        .job_config       (job_config),
        .request_rd_en    (request_rd_en),
        .request_valid    (request_valid),
        .request          (request),
        .done             (done)
    );

    initial ap_clk = 1'b0;
    always #4 ap_clk = ~ap_clk;

    // --------------------------------------------------
    // Random bits and the job table
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    function automatic logic random_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic logic reader_enable(input int mode, input int cycle);
        if (mode == RD_ALWAYS) begin
            return 1'b1;
        end
        if (mode == RD_HOLD && cycle < HOLD_CYCLES) begin
            return 1'b0;
        end
        return random_bit();
    endfunction

    function automatic merge_config_t make_config(
        input logic [`MDG_INDEX_W-1:0] first,
        input logic [`MDG_INDEX_W-1:0] last,
        input logic [`MDG_INDEX_W-1:0] step,
        input logic [`MDG_ADDR_W-1:0]  pointer,
        input logic                    left,
        input logic [`MDG_SHIFT_W-1:0] amount
    );
        merge_config_t c;
        c.index_start   = first;
        c.index_end     = last;
        c.stride        = step;
        c.array_pointer = pointer;
        c.shift_left    = left;
        c.shift_amount  = amount;
        return c;
    endfunction

    task automatic add_row(input merge_config_t cfg, input int mode, input logic extra);
        row_cfg[rows_filled]   = cfg;
        row_mode[rows_filled]  = mode;
        row_extra[rows_filled] = extra;
        rows_filled++;
    endtask

    task automatic fill_table();
        add_row(make_config(32'd0, 32'd10, 32'd1, 64'h0000_1000_0000_0000, 1'b1, 5'd3),
                RD_ALWAYS, 1'b0);
        add_row(make_config(32'd5, 32'd30, 32'd3, 64'h0000_0000_8000_0040, 1'b0, 5'd1),
                RD_RANDOM, 1'b0);
        add_row(make_config(32'd2, 32'd23, 32'd3, 64'h0123_4567_0000_0000, 1'b1, 5'd31),
                RD_ALWAYS, 1'b0);
        // Empty ranges with equal and reversed bounds
        add_row(make_config(32'd50, 32'd50, 32'd1, 64'h0000_0000_0000_2000, 1'b1, 5'd2),
                RD_ALWAYS, 1'b0);
        add_row(make_config(32'd60, 32'd20, 32'd4, 64'h0000_0000_0000_3000, 1'b0, 5'd2),
                RD_RANDOM, 1'b0);
        // Back-pressure over 40 indices
        add_row(make_config(32'd100, 32'd140, 32'd1, 64'h0000_00ff_0000_0000, 1'b1, 5'd2),
                RD_HOLD, 1'b0);
        // Second strobe while busy
        add_row(make_config(32'd0, 32'd24, 32'd1, 64'h0000_0000_4000_0000, 1'b0, 5'd0),
                RD_ALWAYS, 1'b1);
        add_row(make_config(32'd7, 32'd19, 32'd2, 64'h0000_0000_0000_0100, 1'b0, 5'd4),
                RD_RANDOM, 1'b0);
        // Count near the top of the index range
        add_row(make_config(32'hffff_fff0, 32'hffff_ffff, 32'd5, 64'h1000_0000_0000_0000,
                1'b1, 5'd8), RD_ALWAYS, 1'b0);
    endtask

    // --------------------------------------------------
    // Reference model and checks
    // --------------------------------------------------
    task automatic build_expected(input merge_config_t cfg);
        logic [63:0]     count;
        memory_request_t r;
        expected_q.delete();
        count = 64'(cfg.index_start);
        while (count < 64'(cfg.index_end)) begin
            r.base = cfg.array_pointer;
            if (cfg.shift_left) begin
                r.offset = count << cfg.shift_amount;
            end else begin
                r.offset = count >> cfg.shift_amount;
            end
            r.index = count[`MDG_INDEX_W-1:0];
            expected_q.push_back(r);
            count = count + 64'(cfg.stride);
        end
    endtask

    task automatic check_request(input int r, input int n, input memory_request_t got,
                                 input memory_request_t exp);
        if (got.base !== exp.base) begin
            $display("MISMATCH row %0d request %0d request.base: got %h expected %h",
                     r, n, got.base, exp.base);
            error_count++;
        end
        if (got.offset !== exp.offset) begin
            $display("MISMATCH row %0d request %0d request.offset: got %h expected %h",
                     r, n, got.offset, exp.offset);
            error_count++;
        end
        if (got.index !== exp.index) begin
            $display("MISMATCH row %0d request %0d request.index: got %h expected %h",
                     r, n, got.index, exp.index);
            error_count++;
        end
        checked_count++;
    endtask

    // One cycle with the reader on, where no request may arrive
    task automatic watch_idle_cycle(input int r);
        @(posedge ap_clk);
        request_rd_en <= 1'b1;
        @(negedge ap_clk);
        if (request_valid) begin
            $display("Row %0d got an extra request with index %h", r, request.index);
            error_count++;
        end
    endtask

    // --------------------------------------------------
    // One job from strobe to a quiet done
    // --------------------------------------------------
    task automatic run_row(input int r);
        int            cycle;
        int            got;
        int            wait_count;
        merge_config_t other;
        build_expected(row_cfg[r]);
        other               = row_cfg[r];
        other.index_start   = 32'd1000;
        other.index_end     = 32'd1010;
        other.array_pointer = ~row_cfg[r].array_pointer;

        @(posedge ap_clk);
        config_valid  <= 1'b1;
        job_config    <= row_cfg[r];
        request_rd_en <= 1'b0;
        @(posedge ap_clk);
        config_valid <= 1'b0;

        // Done of the previous job clears once the new one starts
        wait_count = 0;
        @(negedge ap_clk);
        while (done && wait_count < 10) begin
            @(negedge ap_clk);
            wait_count++;
        end
        if (done) begin
            $display("Timeout: done did not clear after the config of row %0d", r);
            error_count++;
            aborted = 1'b1;
            return;
        end

        cycle = 0;
        got   = 0;
        while (got < expected_q.size() && cycle < REQ_TIMEOUT) begin
            @(posedge ap_clk);
            request_rd_en <= reader_enable(row_mode[r], cycle);
            config_valid  <= row_extra[r] && (cycle == 4);
            if (row_extra[r] && cycle == 4) begin
                job_config <= other;
            end
            @(negedge ap_clk);
            if (request_valid) begin
                check_request(r, got, request, expected_q[got]);
                got++;
            end
            if (done && (expected_q.size() - got) > `MDG_FIFO_DEPTH + 1) begin
                $display("Row %0d raised done with %0d requests still unwritten",
                         r, expected_q.size() - got);
                error_count++;
            end
            cycle++;
        end
        if (got < expected_q.size()) begin
            $display("Timeout: row %0d delivered %0d of %0d requests",
                     r, got, expected_q.size());
            error_count++;
            aborted = 1'b1;
            return;
        end

        wait_count = 0;
        while (!done && wait_count < DONE_TIMEOUT) begin
            watch_idle_cycle(r);
            wait_count++;
        end
        if (!done) begin
            $display("Timeout: done never rose for row %0d", r);
            error_count++;
            aborted = 1'b1;
            return;
        end
        repeat (QUIET_CYCLES) begin
            watch_idle_cycle(r);
            if (done !== 1'b1) begin
                $display("MISMATCH row %0d done: got %h expected %h", r, done, 1'b1);
                error_count++;
            end
        end
    endtask

    initial begin
        areset_generator = 1'b1;
        config_valid     = 1'b0;
        job_config       = '0;
        request_rd_en    = 1'b0;
        lfsr_state       = 32'hba380e32;
        error_count      = 0;
        checked_count    = 0;
        rows_filled      = 0;
        aborted          = 1'b0;
        fill_table();

        repeat (8) @(posedge ap_clk);
        areset_generator <= 1'b0;

        // Quiet outputs with no job
        repeat (10) begin
            @(negedge ap_clk);
            if (request_valid !== 1'b0) begin
                $display("MISMATCH after reset request_valid: got %h expected %h",
                         request_valid, 1'b0);
                error_count++;
            end
            if (done !== 1'b0) begin
                $display("MISMATCH after reset done: got %h expected %h", done, 1'b0);
                error_count++;
            end
        end

        for (row = 0; row < rows_filled && !aborted; row++) begin
            run_row(row);
        end

        $display("Run finished: %0d requests checked, %0d errors", checked_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/merge_data_generator.sv
// Top level of the index-sequence generator.
// Config regs feed the sequencer, the packer fills the request FIFO.
`timescale 1ns/1ps
`default_nettype none

`include "merge_data_gen_settings.svh"

module merge_data_generator
    import merge_config_pkg::*;
    import memory_packet_pkg::*;
(
    input  logic            ap_clk,
    input  logic            areset_generator,
    input  logic            config_valid,
    input  merge_config_t   job_config,
    input  logic            request_rd_en,
    output logic            request_valid,
    output memory_request_t request,
    output logic            done
);

    // --------------------------------------------------
    // Internal wires
    // --------------------------------------------------
    logic                    start;
    merge_config_t           active_config;
    logic                    busy;
    logic                    push;
    logic [`MDG_INDEX_W-1:0] index;
    logic                    wr_en;
    memory_request_t         din;
    logic                    prog_full;
    logic                    fifo_empty;
    logic                    fifo_rd_en;

    // Pop only when an entry is there
    assign fifo_rd_en = request_rd_en & ~fifo_empty;

    merge_config_regs u_config_regs (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_valid     (config_valid),
        .job_config       (job_config),
        .busy             (busy),
        .start            (start),
        .active_config    (active_config)
    );

    index_sequencer u_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .index_start      (active_config.index_start),
        .index_end        (active_config.index_end),
        .stride           (active_config.stride),
        .prog_full        (prog_full),
        .push             (push),
        .index            (index),
        .busy             (busy),
        .done             (done)
    );

    request_packer u_packer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .index            (index),
        .array_pointer    (active_config.array_pointer),
        .shift_left       (active_config.shift_left),
        .shift_amount     (active_config.shift_amount),
        .wr_en            (wr_en),
        .din              (din)
    );

    request_fifo #(
        .payload_t   (memory_request_t),
        .DEPTH       (`MDG_FIFO_DEPTH),
        .PROG_THRESH (`MDG_PROG_THRESH)
    ) u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (wr_en),
        .din              (din),
        .rd_en            (fifo_rd_en),
        .dout             (request),
        .valid            (request_valid),
        .empty            (fifo_empty),
        .prog_full        (prog_full)
    );

endmodule

`default_nettype wire

// File: logic/request_fifo.sv
// Synchronous FIFO for any packed payload type, with prog_full and read valid.
// dout and valid follow an accepted read by one cycle.
`timescale 1ns/1ps
`default_nettype none

`include "merge_data_gen_settings.svh"

module request_fifo #(
    parameter type payload_t   = logic [31:0],
    parameter int  DEPTH       = `MDG_FIFO_DEPTH,
    parameter int  PROG_THRESH = `MDG_PROG_THRESH
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     valid,
    output logic     empty,
    output logic     prog_full
);

    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] occupancy;
    logic               wr_fire;
    logic               rd_fire;

    assign empty     = (occupancy == '0);
    assign prog_full = (occupancy >= COUNT_W'(PROG_THRESH));
    assign wr_fire   = wr_en & (occupancy != COUNT_W'(DEPTH));
    assign rd_fire   = rd_en & ~empty;

    // --------------------------------------------------
    // Pointers, occupancy and read valid
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            valid     <= 1'b0;
        end else begin
            valid <= rd_fire;
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Storage and output data
    always_ff @(posedge ap_clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= din;
        end
        if (rd_fire) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: logic/request_packer.sv
// Builds an addressed memory request from each pushed index.
// Output is registered, so wr_en follows push by one cycle.
`timescale 1ns/1ps
`default_nettype none

`include "merge_data_gen_settings.svh"

module request_packer
    import memory_packet_pkg::*;
(
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    push,
    input  logic [`MDG_INDEX_W-1:0] index,
    input  logic [`MDG_ADDR_W-1:0]  array_pointer,
    input  logic                    shift_left,
    input  logic [`MDG_SHIFT_W-1:0] shift_amount,
    output logic                    wr_en,
    output memory_request_t         din
);

    memory_request_t             request_next;
    logic [`MDG_ADDR_W-1:0]      index_wide;

    always_comb begin
        index_wide        = {{(`MDG_ADDR_W - `MDG_INDEX_W){1'b0}}, index};
        request_next.base = array_pointer;
        if (shift_left) begin
            request_next.offset = index_wide << shift_amount;
        end else begin
            request_next.offset = index_wide >> shift_amount;
        end
        request_next.index = index;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= push;
        end
    end

    always_ff @(posedge ap_clk) begin
        din <= request_next;
    end

endmodule

`default_nettype wire

// File: logic/index_sequencer.sv
// FSM and stride counter that produce the index sequence of one job.
// Pauses on FIFO prog_full and raises done after the last request is written.
`timescale 1ns/1ps
`default_nettype none

`include "merge_data_gen_settings.svh"

module index_sequencer (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    start,
    input  logic [`MDG_INDEX_W-1:0] index_start,
    input  logic [`MDG_INDEX_W-1:0] index_end,
    input  logic [`MDG_INDEX_W-1:0] stride,
    input  logic                    prog_full,
    output logic                    push,
    output logic [`MDG_INDEX_W-1:0] index,
    output logic                    busy,
    output logic                    done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_RUN,
        ST_PAUSE,
        ST_FINISH
    } seq_state_t;

    seq_state_t state;

    // One extra bit so count + stride cannot wrap below the end index
    logic [`MDG_INDEX_W:0] count;
    logic                  at_end;
    logic                  issue;

    assign at_end = count >= {1'b0, index_end};
    assign issue  = (state == ST_RUN) & ~at_end & ~prog_full;
    assign busy   = (state != ST_IDLE);

    // --------------------------------------------------
    // Control state
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= ST_IDLE;
            push  <= 1'b0;
            done  <= 1'b0;
        end else begin
            push <= issue;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        done  <= 1'b0;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    state <= ST_RUN;
                end
                ST_RUN: begin
                    if (at_end) begin
                        state <= ST_FINISH;
                    end else if (prog_full) begin
                        state <= ST_PAUSE;
                    end
                end
                ST_PAUSE: begin
                    if (!prog_full) begin
                        state <= ST_RUN;
                    end
                end
                ST_FINISH: begin
                    // Last packer write lands at the end of this cycle
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Stride counter and pushed index
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (state == ST_LOAD) begin
            count <= {1'b0, index_start};
        end else if (issue) begin
            index <= count[`MDG_INDEX_W-1:0];
            count <= count + {1'b0, stride};
        end
    end

endmodule

`default_nettype wire

// File: logic/merge_config_regs.sv
// Holds the configuration of the running job and starts the sequencer.
// A config strobe is taken only while the sequencer is idle.
`timescale 1ns/1ps
`default_nettype none

module merge_config_regs
    import merge_config_pkg::*;
(
    input  logic          ap_clk,
    input  logic          areset_generator,
    input  logic          config_valid,
    input  merge_config_t job_config,
    input  logic          busy,
    output logic          start,
    output merge_config_t active_config
);

    logic accept;

    // Start is high in the cycle before busy rises, so it blocks too
    assign accept = config_valid & ~busy & ~start;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start <= 1'b0;
        end else begin
            start <= accept;
        end
    end

    // Job payload, stable until the next accepted strobe
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            active_config <= job_config;
        end
    end

endmodule

`default_nettype wire

// File: logic/memory_packet_pkg.sv
// Memory request payload sent to the edge-list reader.
// Imported by the packer and the top level, and used as the FIFO payload type.
`default_nettype none

`include "merge_data_gen_settings.svh"

package memory_packet_pkg;

    // Address is base + offset, index is the raw count
    typedef struct packed {
        logic [`MDG_ADDR_W-1:0]  base;
        logic [`MDG_ADDR_W-1:0]  offset;
        logic [`MDG_INDEX_W-1:0] index;
    } memory_request_t;

endpackage

`default_nettype wire

// File: logic/merge_config_pkg.sv
// Job configuration type written by the host.
// Imported by the config register block and the top level.
`default_nettype none

`include "merge_data_gen_settings.svh"

package merge_config_pkg;

    // --------------------------------------------------
    // One job: index range, stride and addressing
    // --------------------------------------------------
    typedef struct packed {
        // Range is [index_start, index_end)
        logic [`MDG_INDEX_W-1:0] index_start;
        logic [`MDG_INDEX_W-1:0] index_end;
        logic [`MDG_INDEX_W-1:0] stride;

        // Base of the array the indices point into
        logic [`MDG_ADDR_W-1:0]  array_pointer;

        // 1 shifts the index left, 0 shifts it right
        logic                    shift_left;
        logic [`MDG_SHIFT_W-1:0] shift_amount;
    } merge_config_t;

endpackage

`default_nettype wire

// File: include/merge_data_gen_settings.svh
// Width, depth and threshold settings shared by the index-sequence generator.
// Included by the packages and by every module that sizes a port from them.
`ifndef MERGE_DATA_GEN_SETTINGS_SVH
`define MERGE_DATA_GEN_SETTINGS_SVH

// One index word, also used for the stride and the counter
`define MDG_INDEX_W 32

// Base pointer and byte offset
`define MDG_ADDR_W 64

// Shift amount applied to the index
`define MDG_SHIFT_W 5

// Request FIFO entries and the fill level where prog_full rises
`define MDG_FIFO_DEPTH 16
`define MDG_PROG_THRESH 8

`endif
